//--- source/l2_pkg.sv
////////////////////////////////////////
// L2 cache shared definitions
// Geometry, packet layouts and bus FSM states
////////////////////////////////////////
package l2_pkg;
	localparam int NUM_CORES = 2;
	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 8;
	localparam int ADDR_BITS = 10;	// Word address
	localparam int MISS_QUEUE_DEPTH = 4;
	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int PIPE_DEPTH = 3;	// Slots that may still push a miss

	typedef logic [ADDR_BITS-1:0] l2_addr_t;
	typedef logic [31:0] l2_data_t;	// One word per line
	typedef logic [SET_BITS-1:0] l2_set_idx_t;
	typedef logic [ADDR_BITS-SET_BITS-1:0] l2_tag_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] l2_way_idx_t;
	typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;
	typedef logic [$clog2(NUM_WAYS*NUM_SETS)-1:0] l2_line_idx_t;	// {way, set}
	typedef logic [$clog2(MISS_QUEUE_DEPTH+1)-1:0] l2_queue_cnt_t;
	typedef logic [$clog2(MISS_QUEUE_DEPTH)-1:0] l2_queue_ptr_t;

	typedef enum logic {
		L2_LOAD,
		L2_STORE
	} l2_op_t;

	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_WB_REQ,
		BUS_WB_RELEASE,
		BUS_RD_REQ,
		BUS_RD_RELEASE,
		BUS_RESTART,
		BUS_WAIT_FILL
	} bus_state_t;

	typedef struct packed {
		logic valid;
		l2_op_t op;
		core_id_t core;
		l2_addr_t addr;
		l2_data_t data;	// Store data
	} l2_request_t;

	typedef struct packed {
		logic valid;
		l2_op_t op;
		core_id_t core;
		l2_addr_t addr;
		l2_data_t data;	// Loaded or stored value
	} l2_response_t;

	typedef struct packed {
		l2_request_t request;
		logic is_fill;	// Restarted after a memory read
		l2_data_t fill_data;
	} l2_stage_t;

	typedef struct packed {
		logic write;
		l2_addr_t addr;
		l2_data_t data;
	} mem_cmd_t;

	typedef struct packed {
		logic valid;
		l2_addr_t addr;
		l2_data_t data;
	} l2_writeback_t;
endpackage

//--- source/l2_cache_arb.sv
////////////////////////////////////////
// L2 arbitrate stage
// Restart first, else round robin cores
////////////////////////////////////////
module l2_cache_arb(
	input  logic                  clk,
	input  logic                  rst_n,
	input  l2_pkg::l2_request_t   core_request[l2_pkg::NUM_CORES],
	output logic                  core_ready[l2_pkg::NUM_CORES],
	input  logic                  restart_valid,
	input  l2_pkg::l2_stage_t     restart,
	input  l2_pkg::l2_queue_cnt_t miss_queue_free,
	output l2_pkg::l2_stage_t     arb_stage);

	logic ready_en;	// Held low for one edge out of reset
	logic accept_ok;
	logic grant_valid;
	l2_pkg::core_id_t grant_id;
	l2_pkg::core_id_t rr_ptr;	// Core with first claim

	// Search from the pointer for the first valid core
	always_comb begin
		l2_pkg::core_id_t cand;
		grant_valid = 1'b0;
		grant_id = rr_ptr;
		for (int i = 0; i < l2_pkg::NUM_CORES; i++) begin
			cand = l2_pkg::core_id_t'(rr_ptr + l2_pkg::core_id_t'(i));
			if (!grant_valid && core_request[cand].valid) begin
				grant_valid = 1'b1;
				grant_id = cand;
			end
		end
	end

	// No core slot while a restart wins, or the miss queue lacks room
	assign accept_ok = ready_en && !restart_valid
		&& miss_queue_free >= l2_pkg::l2_queue_cnt_t'(l2_pkg::PIPE_DEPTH);

	always_comb begin
		for (int i = 0; i < l2_pkg::NUM_CORES; i++)
			core_ready[i] = accept_ok && grant_id == l2_pkg::core_id_t'(i);	// Winner only
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_en <= 1'b0;
			rr_ptr <= '0;
			arb_stage <= '0;
		end else begin
			ready_en <= 1'b1;
			if (restart_valid)
				arb_stage <= restart;	// Fill always goes in
			else if (accept_ok && grant_valid) begin
				arb_stage.request <= core_request[grant_id];
				arb_stage.request.core <= grant_id;	// Tag with the granted port
				arb_stage.is_fill <= 1'b0;
				arb_stage.fill_data <= '0;
				rr_ptr <= l2_pkg::core_id_t'(grant_id + 1'b1);	// Past the winner
			end else
				arb_stage <= '0;	// Bubble
		end
	end
endmodule

//--- source/l2_cache_tag.sv
////////////////////////////////////////
// L2 tag stage
// Tag, valid, dirty and LRU state per set
////////////////////////////////////////
module l2_cache_tag(
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  l2_pkg::l2_stage_t                        arb_stage,
	input  logic                                     tag_update_en,
	input  l2_pkg::l2_set_idx_t                      tag_update_set,
	input  l2_pkg::l2_way_idx_t                      tag_update_way,
	input  l2_pkg::l2_tag_t                          tag_update_tag,
	input  logic                                     tag_update_valid,
	input  logic                                     dirty_update_value,
	input  logic                                     lru_update_en,
	input  l2_pkg::l2_way_idx_t                      lru_update_way,
	output l2_pkg::l2_stage_t                        tag_stage,
	output l2_pkg::l2_tag_t [l2_pkg::NUM_WAYS-1:0]   way_tag,
	output logic [l2_pkg::NUM_WAYS-1:0]              way_valid,
	output logic [l2_pkg::NUM_WAYS-1:0]              way_dirty,
	output l2_pkg::l2_way_idx_t                      lru_way);

	l2_pkg::l2_tag_t tag_array[l2_pkg::NUM_SETS][l2_pkg::NUM_WAYS];
	logic [l2_pkg::NUM_WAYS-1:0] valid_array[l2_pkg::NUM_SETS];
	logic [l2_pkg::NUM_WAYS-1:0] dirty_array[l2_pkg::NUM_SETS];
	l2_pkg::l2_way_idx_t lru_array[l2_pkg::NUM_SETS];	// Way to evict next
	l2_pkg::l2_set_idx_t read_set;
	logic set_match;	// Update hits the set being read

	assign read_set = arb_stage.request.addr[l2_pkg::SET_BITS-1:0];
	assign set_match = tag_update_set == read_set;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < l2_pkg::NUM_SETS; s++) begin
				valid_array[s] <= '0;
				dirty_array[s] <= '0;
				lru_array[s] <= '0;
			end
		end else begin
			if (tag_update_en) begin
				valid_array[tag_update_set][tag_update_way] <= tag_update_valid;
				dirty_array[tag_update_set][tag_update_way] <= dirty_update_value;
			end
			if (lru_update_en)
				lru_array[tag_update_set] <= lru_update_way;	// Same set as tag port
		end
	end

	always_ff @(posedge clk) begin
		if (tag_update_en)
			tag_array[tag_update_set][tag_update_way] <= tag_update_tag;
	end

	// Registered read, newest update wins
	always_ff @(posedge clk) begin
		for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
			if (tag_update_en && set_match && tag_update_way == l2_pkg::l2_way_idx_t'(w)) begin
				way_tag[w] <= tag_update_tag;
				way_valid[w] <= tag_update_valid;
				way_dirty[w] <= dirty_update_value;
			end else begin
				way_tag[w] <= tag_array[read_set][w];
				way_valid[w] <= valid_array[read_set][w];
				way_dirty[w] <= dirty_array[read_set][w];
			end
		end
		lru_way <= (lru_update_en && set_match) ? lru_update_way : lru_array[read_set];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tag_stage <= '0;
		else
			tag_stage <= arb_stage;
	end
endmodule

//--- source/l2_cache_read.sv
////////////////////////////////////////
// L2 read stage
// Hit check, data read, tag and LRU update
////////////////////////////////////////
module l2_cache_read(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  l2_pkg::l2_stage_t                      tag_stage,
	input  l2_pkg::l2_tag_t [l2_pkg::NUM_WAYS-1:0] way_tag,
	input  logic [l2_pkg::NUM_WAYS-1:0]            way_valid,
	input  logic [l2_pkg::NUM_WAYS-1:0]            way_dirty,
	input  l2_pkg::l2_way_idx_t                    lru_way,
	input  logic                                   data_write_en,
	input  l2_pkg::l2_line_idx_t                   data_write_idx,
	input  l2_pkg::l2_data_t                       data_write_data,
	output logic                                   tag_update_en,
	output l2_pkg::l2_set_idx_t                    tag_update_set,
	output l2_pkg::l2_way_idx_t                    tag_update_way,
	output l2_pkg::l2_tag_t                        tag_update_tag,
	output logic                                   tag_update_valid,
	output logic                                   dirty_update_value,
	output logic                                   lru_update_en,
	output l2_pkg::l2_way_idx_t                    lru_update_way,
	output l2_pkg::l2_stage_t                      read_stage,
	output logic                                   read_hit,
	output l2_pkg::l2_way_idx_t                    read_way,
	output l2_pkg::l2_data_t                       read_data,
	output l2_pkg::l2_writeback_t                  victim);

	l2_pkg::l2_data_t data_array[l2_pkg::NUM_WAYS*l2_pkg::NUM_SETS];
	l2_pkg::l2_set_idx_t req_set;
	l2_pkg::l2_tag_t req_tag;
	logic is_store;
	logic hit;
	l2_pkg::l2_way_idx_t hit_way;
	l2_pkg::l2_way_idx_t access_way;	// Hit way, or victim for a fill
	l2_pkg::l2_line_idx_t line_idx;
	l2_pkg::l2_data_t line_data;
	l2_pkg::l2_writeback_t victim_next;

	assign req_set = tag_stage.request.addr[l2_pkg::SET_BITS-1:0];
	assign req_tag = tag_stage.request.addr[l2_pkg::ADDR_BITS-1:l2_pkg::SET_BITS];
	assign is_store = tag_stage.request.op == l2_pkg::L2_STORE;

	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
			if (way_valid[w] && way_tag[w] == req_tag) begin
				hit = 1'b1;
				hit_way = l2_pkg::l2_way_idx_t'(w);
			end
		end
	end

	assign access_way = hit ? hit_way : lru_way;
	assign line_idx = {access_way, req_set};
	// Write from the update stage in this cycle is newer than the array
	assign line_data = (data_write_en && data_write_idx == line_idx) ? data_write_data
		: data_array[line_idx];

	// Hits touch the line, fills that miss install a new tag
	assign tag_update_en = tag_stage.request.valid && (hit || tag_stage.is_fill);
	assign tag_update_set = req_set;
	assign tag_update_way = access_way;
	assign tag_update_tag = req_tag;
	assign tag_update_valid = 1'b1;
	assign dirty_update_value = is_store || (hit && way_dirty[access_way]);	// Load fill is clean
	assign lru_update_en = tag_update_en;
	assign lru_update_way = ~access_way;	// Other way goes next

	// Dirty victim of a fresh fill
	assign victim_next.valid = tag_stage.request.valid && tag_stage.is_fill && !hit
		&& way_valid[lru_way] && way_dirty[lru_way];
	assign victim_next.addr = {way_tag[lru_way], req_set};
	assign victim_next.data = line_data;

	always_ff @(posedge clk) begin
		if (data_write_en)
			data_array[data_write_idx] <= data_write_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_stage <= '0;
			read_hit <= 1'b0;
			victim <= '0;
		end else begin
			read_stage <= tag_stage;
			read_hit <= hit;
			victim <= victim_next;
		end
	end

	always_ff @(posedge clk) begin
		read_way <= access_way;
		read_data <= line_data;
	end
endmodule

//--- source/l2_cache_update.sv
////////////////////////////////////////
// L2 update stage
// Data write, response and miss handoff
////////////////////////////////////////
module l2_cache_update(
	input  logic                  clk,
	input  logic                  rst_n,
	input  l2_pkg::l2_stage_t     read_stage,
	input  logic                  read_hit,
	input  l2_pkg::l2_way_idx_t   read_way,
	input  l2_pkg::l2_data_t      read_data,
	input  l2_pkg::l2_writeback_t victim,
	output logic                  data_write_en,
	output l2_pkg::l2_line_idx_t  data_write_idx,
	output l2_pkg::l2_data_t      data_write_data,
	output l2_pkg::l2_response_t  response,
	output logic                  miss_push,
	output l2_pkg::l2_request_t   miss_request,
	output logic                  fill_done,
	output l2_pkg::l2_writeback_t fill_writeback);

	l2_pkg::l2_request_t req;
	logic is_store;
	logic served;	// Hit or fill, answered now
	logic fresh_fill;	// Fill that takes the memory data

	assign req = read_stage.request;
	assign is_store = req.op == l2_pkg::L2_STORE;
	assign served = req.valid && (read_hit || read_stage.is_fill);
	assign fresh_fill = read_stage.is_fill && !read_hit;	// Collided fill drops memory data

	assign data_write_en = served && (is_store || fresh_fill);
	assign data_write_idx = {read_way, req.addr[l2_pkg::SET_BITS-1:0]};
	assign data_write_data = is_store ? req.data : read_stage.fill_data;

	assign miss_push = req.valid && !read_hit && !read_stage.is_fill;
	assign miss_request = req;
	assign fill_done = req.valid && read_stage.is_fill;	// Frees the bus FSM
	assign fill_writeback = victim;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			response <= '0;
		else begin
			response.valid <= served;
			response.op <= req.op;
			response.core <= req.core;
			response.addr <= req.addr;
			if (is_store)
				response.data <= req.data;
			else
				response.data <= fresh_fill ? read_stage.fill_data : read_data;
		end
	end
endmodule

//--- source/l2_bus_interface.sv
////////////////////////////////////////
// L2 bus interface
// Miss FIFO, memory req/ack and fill restart
////////////////////////////////////////
module l2_bus_interface(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  miss_push,
	input  l2_pkg::l2_request_t   miss_request,
	input  logic                  fill_done,
	input  l2_pkg::l2_writeback_t fill_writeback,
	output l2_pkg::l2_queue_cnt_t miss_queue_free,
	output logic                  restart_valid,
	output l2_pkg::l2_stage_t     restart,
	output logic                  mem_req,
	output l2_pkg::mem_cmd_t      mem_cmd,
	input  logic                  mem_ack,
	input  l2_pkg::l2_data_t      mem_rdata);

	l2_pkg::l2_request_t queue[l2_pkg::MISS_QUEUE_DEPTH];
	l2_pkg::l2_queue_ptr_t head;
	l2_pkg::l2_queue_ptr_t tail;
	l2_pkg::l2_queue_cnt_t count;
	l2_pkg::bus_state_t state;
	l2_pkg::l2_data_t read_line;	// Word from the last memory read
	logic pop;

	assign pop = state == l2_pkg::BUS_RESTART;	// Head leaves as it restarts
	// Same-cycle push already counted so the arbiter sees true room
	assign miss_queue_free = l2_pkg::l2_queue_cnt_t'(l2_pkg::MISS_QUEUE_DEPTH) - count
		- l2_pkg::l2_queue_cnt_t'(miss_push);
	assign restart_valid = pop;
	assign mem_req = state == l2_pkg::BUS_RD_REQ || state == l2_pkg::BUS_WB_REQ;

	always_comb begin
		restart.request = queue[head];
		restart.is_fill = 1'b1;
		restart.fill_data = read_line;
	end

	always_ff @(posedge clk) begin
		if (miss_push)
			queue[tail] <= miss_request;
		if (state == l2_pkg::BUS_RD_REQ && mem_ack)
			read_line <= mem_rdata;	// Sampled while ack is high
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			state <= l2_pkg::BUS_IDLE;
			mem_cmd <= '0;
		end else begin
			if (miss_push)
				tail <= tail + 1'b1;
			if (miss_push && !pop)
				count <= count + 1'b1;
			else if (!miss_push && pop)
				count <= count - 1'b1;

			case (state)
				l2_pkg::BUS_IDLE: begin
					if (count != '0) begin
						mem_cmd <= '{write: 1'b0, addr: queue[head].addr, data: '0};
						state <= l2_pkg::BUS_RD_REQ;
					end
				end
				l2_pkg::BUS_RD_REQ: if (mem_ack) state <= l2_pkg::BUS_RD_RELEASE;
				l2_pkg::BUS_RD_RELEASE: if (!mem_ack) state <= l2_pkg::BUS_RESTART;
				l2_pkg::BUS_RESTART: begin
					head <= head + 1'b1;
					state <= l2_pkg::BUS_WAIT_FILL;	// Offered for one cycle
				end
				l2_pkg::BUS_WAIT_FILL: begin
					if (fill_done && fill_writeback.valid) begin
						// Victim goes out before any further read
						mem_cmd <= '{write: 1'b1, addr: fill_writeback.addr,
							data: fill_writeback.data};
						state <= l2_pkg::BUS_WB_REQ;
					end else if (fill_done)
						state <= l2_pkg::BUS_IDLE;
				end
				l2_pkg::BUS_WB_REQ: if (mem_ack) state <= l2_pkg::BUS_WB_RELEASE;
				l2_pkg::BUS_WB_RELEASE: if (!mem_ack) state <= l2_pkg::BUS_IDLE;
				default: state <= l2_pkg::BUS_IDLE;
			endcase
		end
	end
endmodule

//--- source/l2_cache.sv
////////////////////////////////////////
// Shared two-core L2 cache
// Four pipeline stages and a bus interface
////////////////////////////////////////
module l2_cache(
	input  logic                 clk,
	input  logic                 rst_n,
	input  l2_pkg::l2_request_t  core_request[l2_pkg::NUM_CORES],
	output logic                 core_ready[l2_pkg::NUM_CORES],
	output l2_pkg::l2_response_t response,
	output logic                 mem_req,
	output l2_pkg::mem_cmd_t     mem_cmd,
	input  logic                 mem_ack,
	input  l2_pkg::l2_data_t     mem_rdata);

	// Restart path and miss queue room
	logic restart_valid;
	l2_pkg::l2_stage_t restart;
	l2_pkg::l2_queue_cnt_t miss_queue_free;

	// Stage registers
	l2_pkg::l2_stage_t arb_stage;
	l2_pkg::l2_stage_t tag_stage;
	l2_pkg::l2_stage_t read_stage;

	// Tag write port from the read stage
	logic tag_update_en;
	l2_pkg::l2_set_idx_t tag_update_set;
	l2_pkg::l2_way_idx_t tag_update_way;
	l2_pkg::l2_tag_t tag_update_tag;
	logic tag_update_valid;
	logic dirty_update_value;
	logic lru_update_en;
	l2_pkg::l2_way_idx_t lru_update_way;

	// Tag read results
	l2_pkg::l2_tag_t [l2_pkg::NUM_WAYS-1:0] way_tag;
	logic [l2_pkg::NUM_WAYS-1:0] way_valid;
	logic [l2_pkg::NUM_WAYS-1:0] way_dirty;
	l2_pkg::l2_way_idx_t lru_way;

	// Data array write port from the update stage
	logic data_write_en;
	l2_pkg::l2_line_idx_t data_write_idx;
	l2_pkg::l2_data_t data_write_data;

	logic read_hit;
	l2_pkg::l2_way_idx_t read_way;
	l2_pkg::l2_data_t read_data;
	l2_pkg::l2_writeback_t victim;

	// Update stage to bus interface
	logic miss_push;
	l2_pkg::l2_request_t miss_request;
	logic fill_done;
	l2_pkg::l2_writeback_t fill_writeback;

	l2_cache_arb l2_cache_arb(.*);
	l2_cache_tag l2_cache_tag(.*);
	l2_cache_read l2_cache_read(.*);
	l2_cache_update l2_cache_update(.*);
	l2_bus_interface l2_bus_interface(.*);
endmodule

//--- bench/tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock source
// Free running, 100 ns period
////////////////////////////////////////
module tb_clock_gen(
	output logic clk);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// Half period
	end
endmodule

//--- bench/l2_cache_assert.sv
////////////////////////////////////////
// L2 cache protocol assertions
// Reset quiet and memory req/ack rules
////////////////////////////////////////
module l2_cache_assert(
	input logic             clk,
	input logic             rst_n,
	input logic             core_ready[l2_pkg::NUM_CORES],
	input l2_pkg::l2_response_t response,
	input logic             mem_req,
	input l2_pkg::mem_cmd_t mem_cmd,
	input logic             mem_ack);
	timeunit 1ns;
	timeprecision 1ps;

	int failures;	// Read by the testbench at the end

	initial failures = 0;

	// First edge out of reset sees no activity
	property quiet_after_reset;
		@(posedge clk) $rose(rst_n) |-> !core_ready[0] && !core_ready[1]
			&& !response.valid && !mem_req;
	endproperty

	// Request and command hold until ack
	property req_held_until_ack;
		@(posedge clk) disable iff (!rst_n)
			mem_req && !mem_ack |=> mem_req && $stable(mem_cmd);
	endproperty

	property no_req_over_ack;
		@(posedge clk) disable iff (!rst_n) $rose(mem_req) |-> !mem_ack;
	endproperty

	a_quiet: assert property (quiet_after_reset) else begin
		$error("core_ready, response or mem_req active right after reset");
		failures++;
	end
	a_held: assert property (req_held_until_ack) else begin
		$error("mem_req or mem_cmd changed before mem_ack");
		failures++;
	end
	a_four_phase: assert property (no_req_over_ack) else begin
		$error("mem_req rose while mem_ack was still high");
		failures++;
	end
endmodule

bind l2_cache l2_cache_assert u_assert(
	.clk(clk),
	.rst_n(rst_n),
	.core_ready(core_ready),
	.response(response),
	.mem_req(mem_req),
	.mem_cmd(mem_cmd),
	.mem_ack(mem_ack));

//--- bench/l2_cache_tb.sv
////////////////////////////////////////
// L2 cache testbench
// Two random cores, a req/ack memory and
// a flat reference model of all words
////////////////////////////////////////
module l2_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TRANS = 300;	// Per core
	localparam int ADDR_SPAN = 48;	// Six tags per set, lots of conflicts
	localparam int WAIT_LIMIT = 2000;	// Cycles
	localparam int MEM_IDLE_LIMIT = 5000;
	localparam int HIT_LATENCY = 4;

	logic clk;
	logic rst_n;
	l2_pkg::l2_request_t core_request[l2_pkg::NUM_CORES];
	logic core_ready[l2_pkg::NUM_CORES];
	l2_pkg::l2_response_t response;
	logic mem_req;
	l2_pkg::mem_cmd_t mem_cmd;
	logic mem_ack;
	l2_pkg::l2_data_t mem_rdata;

	l2_pkg::l2_data_t mem_array[1 << l2_pkg::ADDR_BITS];	// Backing memory
	l2_pkg::l2_data_t model[1 << l2_pkg::ADDR_BITS];	// Value each load must return
	logic busy[l2_pkg::NUM_CORES];	// Accepted and not yet answered
	int resp_count;	// Responses so far
	int active_cores;
	int mismatch_count;
	int failure_count;
	int hit_checks;

	tb_clock_gen u_clock(
		.clk(clk));

	l2_cache u_dut(
		.clk(clk),
		.rst_n(rst_n),
		.core_request(core_request),
		.core_ready(core_ready),
		.response(response),
		.mem_req(mem_req),
		.mem_cmd(mem_cmd),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata));

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	// A response for an idle core
	task automatic check_stray(input int c);
		if (response.valid && response.core == l2_pkg::core_id_t'(c)) begin
			failure_count++;
			$display("Core %0d got a response with no request outstanding at %0t", c, $time);
		end
	endtask

	task automatic run_core(input int c);
		l2_pkg::l2_request_t req;
		l2_pkg::l2_addr_t last_addr;
		logic have_last;
		logic done;
		logic expect_hit;
		int saved_resp;
		int waited;
		int gap;
		have_last = 1'b0;
		last_addr = '0;
		saved_resp = -1;
		for (int n = 0; n < NUM_TRANS; n++) begin
			gap = $urandom_range(6, 0);
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				check_stray(c);
			end
			req.valid = 1'b1;
			req.op = ($urandom_range(1, 0) == 1) ? l2_pkg::L2_STORE : l2_pkg::L2_LOAD;
			req.core = l2_pkg::core_id_t'(c);
			if (have_last && $urandom_range(3, 0) == 0)
				req.addr = last_addr;	// Repeat, may be a known hit
			else
				req.addr = l2_pkg::l2_addr_t'($urandom_range(ADDR_SPAN - 1, 0));
			req.data = $urandom();
			core_request[c] <= req;

			// Valid held until ready seen on the same edge
			done = 1'b0;
			waited = 0;
			while (!done && waited < WAIT_LIMIT) begin
				@(posedge clk);
				check_stray(c);
				done = core_ready[c];
				waited++;
			end
			if (!done) begin
				failure_count++;
				$display("Core %0d request was never accepted", c);
				return;
			end
			core_request[c] <= '0;
			busy[c] <= 1'b1;
			// Line still resident if nothing else ran since our last answer
			expect_hit = have_last && req.addr == last_addr && resp_count == saved_resp
				&& !busy[1 - c];

			done = 1'b0;
			waited = 0;
			while (!done && waited < WAIT_LIMIT) begin
				@(posedge clk);
				waited++;
				done = response.valid && response.core == l2_pkg::core_id_t'(c);
			end
			if (!done) begin
				failure_count++;
				$display("Core %0d request at address %0d got no response", c, req.addr);
				return;
			end
			check_value("response.op", 32'(response.op), 32'(req.op));
			check_value("response.addr", 32'(response.addr), 32'(req.addr));
			if (req.op == l2_pkg::L2_STORE) begin
				check_value("response.data", response.data, req.data);
				model[req.addr] = req.data;	// Store takes effect here
			end else
				check_value("response.data", response.data, model[req.addr]);
			if (expect_hit) begin
				hit_checks++;
				check_value("hit latency", waited, HIT_LATENCY);
			end
			busy[c] <= 1'b0;
			saved_resp = resp_count + 1;
			resp_count <= resp_count + 1;	// One response per edge at most
			last_addr = req.addr;
			have_last = 1'b1;
		end
	endtask

	// Four-phase memory with random ack and release delays
	task automatic serve_memory();
		l2_pkg::mem_cmd_t cmd;
		logic running;
		int waited;
		running = 1'b1;
		while (running) begin
			waited = 0;
			while (!mem_req && active_cores != 0 && waited < MEM_IDLE_LIMIT) begin
				@(posedge clk);
				waited++;
			end
			if (!mem_req) begin
				if (active_cores != 0) begin
					failure_count++;
					$display("Memory saw no request for %0d cycles", MEM_IDLE_LIMIT);
				end
				running = 1'b0;
			end else begin
				repeat ($urandom_range(3, 0)) @(posedge clk);
				cmd = mem_cmd;
				if (cmd.write) begin
					// Write-back must carry the newest value of the line
					check_value("mem_cmd.data", cmd.data, model[cmd.addr]);
					mem_array[cmd.addr] = cmd.data;
				end
				mem_ack <= 1'b1;
				mem_rdata <= cmd.write ? '0 : mem_array[cmd.addr];
				waited = 0;
				while (mem_req && waited < WAIT_LIMIT) begin
					@(posedge clk);
					waited++;
				end
				if (mem_req) begin
					failure_count++;
					$display("mem_req stayed high after mem_ack");
					running = 1'b0;
				end else begin
					repeat ($urandom_range(2, 0)) @(posedge clk);
					mem_ack <= 1'b0;
					@(posedge clk);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(94976));
		mismatch_count = 0;
		failure_count = 0;
		hit_checks = 0;
		active_cores = l2_pkg::NUM_CORES;
		for (int a = 0; a < (1 << l2_pkg::ADDR_BITS); a++) begin
			mem_array[a] = $urandom();
			model[a] = mem_array[a];	// Same start as memory
		end
		rst_n <= 1'b0;
		mem_ack <= 1'b0;
		mem_rdata <= '0;
		resp_count <= 0;
		for (int c = 0; c < l2_pkg::NUM_CORES; c++) begin
			core_request[c] <= '0;
			busy[c] <= 1'b0;
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		fork
			begin
				run_core(0);
				active_cores--;
			end
			begin
				run_core(1);
				active_cores--;
			end
			serve_memory();
		join

		$display("Summary: %0d mismatches, %0d other failures, %0d assertion failures, %0d hit checks",
			mismatch_count, failure_count, u_dut.u_assert.failures, hit_checks);
		if (mismatch_count == 0 && failure_count == 0 && u_dut.u_assert.failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end
endmodule

//--- sources.f
source/l2_pkg.sv
source/l2_cache_arb.sv
source/l2_cache_tag.sv
source/l2_cache_read.sv
source/l2_cache_update.sv
source/l2_bus_interface.sv
source/l2_cache.sv
bench/tb_clock_gen.sv
bench/l2_cache_assert.sv
bench/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module l2_cache_tb -o l2_cache_sim

out=$(./obj_dir/l2_cache_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
